// ==== bpu.f ====
common/bpu_pred_pkg.sv
common/bpu_stats_pkg.sv
common/bpu_bank_if.sv
predictor/bank_router.sv
predictor/pred_bank.sv
predictor/pred_merge.sv
logic/pred_stats.sv
logic/branch_predictor_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_top -f bpu.f -o tb_sim \
   > sim.log 2>&1 &&
   ./obj_dir/tb_sim >> sim.log 2>&1 ||
   echo "Build or simulation stopped early" >> sim.log
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" ||
   { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tests/tb_top.sv ====
module tb_top;

   localparam int NUM_CYCLES = 3000;
   localparam int POOL_SIZE  = 40;
   localparam int WAIT_LIMIT = 200;

   // Same names as the DUT ports
   logic        clk_i;
   logic        rst_i;
   logic        lookup_valid_i;
   logic [31:0] lookup_pc_i;
   logic        update_valid_i;
   logic        update_taken_i;
   logic [31:0] update_pc_i;
   logic [31:0] update_target_i;
   logic        mispredict_i;
   logic        pred_valid_o;
   logic        pred_taken_o;
   logic [31:0] pred_target_o;
   logic [15:0] stat_lookups_o;
   logic [15:0] stat_taken_o;
   logic [15:0] stat_updates_o;
   logic [15:0] stat_mispredicts_o;

   int          checks;
   int          pred_errors;
   int          stat_errors;
   int          timeouts;
   int          waited;
   integer      seed;
   logic [31:0] pc_pool [POOL_SIZE];

   tb_clock u_clock (
      .clk_o (clk_i),
      .rst_o (rst_i)
   );

   branch_predictor_top dut (.*);

   tb_checker u_checker (
      .clk_i              (clk_i),
      .rst_i              (rst_i),
      .lookup_valid_i     (lookup_valid_i),
      .lookup_pc_i        (lookup_pc_i),
      .update_valid_i     (update_valid_i),
      .update_taken_i     (update_taken_i),
      .update_pc_i        (update_pc_i),
      .update_target_i    (update_target_i),
      .mispredict_i       (mispredict_i),
      .pred_valid_i       (pred_valid_o),
      .pred_taken_i       (pred_taken_o),
      .pred_target_i      (pred_target_o),
      .stat_lookups_i     (stat_lookups_o),
      .stat_taken_i       (stat_taken_o),
      .stat_updates_i     (stat_updates_o),
      .stat_mispredicts_i (stat_mispredicts_o),
      .checks_o           (checks),
      .pred_errors_o      (pred_errors),
      .stat_errors_o      (stat_errors)
   );

   // Thirty random PCs, then ten that reuse bank and row (bits 7..1) with a new tag
   task automatic build_pool();
      for (int i = 0; i < POOL_SIZE; i++) begin
         if (i < 30) begin
            pc_pool[i] = $random(seed) & 32'hFFFF_FFFE;
         end else begin
            pc_pool[i] = {pc_pool[i-30][31:8] ^ 24'(i), pc_pool[i-30][7:0]};
         end
      end
   endtask

   task automatic drive_random_cycle();
      int lookup_pick;
      int update_pick;
      lookup_pick = int'({$random(seed)} % POOL_SIZE);
      update_pick = int'({$random(seed)} % POOL_SIZE);
      if (($random(seed) & 7) == 0) begin
         update_pick = lookup_pick; // Lookup and update hit one row together
      end
      lookup_valid_i  <= ($random(seed) & 3) != 0;
      lookup_pc_i     <= pc_pool[lookup_pick];
      update_valid_i  <= ($random(seed) & 1) != 0;
      update_taken_i  <= ({$random(seed)} % 10) < 7; // Mostly taken
      update_pc_i     <= pc_pool[update_pick];
      update_target_i <= $random(seed) & 32'hFFFF_FFFE;
      mispredict_i    <= ($random(seed) % 5) == 0;
   endtask

   initial begin
      seed            = 29;
      timeouts        = 0;
      lookup_valid_i  = 1'b0;
      lookup_pc_i     = '0;
      update_valid_i  = 1'b0;
      update_taken_i  = 1'b0;
      update_pc_i     = '0;
      update_target_i = '0;
      mispredict_i    = 1'b0;
      build_pool();

      waited = 0;
      while (rst_i !== 1'b0 && waited < WAIT_LIMIT) begin
         @(negedge clk_i);
         waited++;
      end
      if (rst_i !== 1'b0) begin
         $display("Timeout: reset was still asserted after %0d cycles", WAIT_LIMIT);
         timeouts++;
      end else begin
         for (int c = 0; c < NUM_CYCLES; c++) begin
            @(posedge clk_i);
            drive_random_cycle();
         end
         @(posedge clk_i);
         lookup_valid_i <= 1'b0;
         update_valid_i <= 1'b0;
         mispredict_i   <= 1'b0;

         // Last prediction drains out
         waited = 0;
         @(negedge clk_i);
         while (pred_valid_o !== 1'b0 && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
         end
         if (pred_valid_o !== 1'b0) begin
            $display("Timeout: pred_valid_o stayed high after the last lookup");
            timeouts++;
         end
      end

      @(posedge clk_i);
      $display("Summary: %0d checks, %0d prediction errors, %0d counter errors, %0d timeouts",
               checks, pred_errors, stat_errors, timeouts);
      if (pred_errors == 0 && stat_errors == 0 && timeouts == 0 && checks > 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== tests/tb_checker.sv ====
module tb_checker #(
   parameter int NUM_BANKS     = 4,
   parameter int ROWS_PER_BANK = 32
) (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        lookup_valid_i,
   input  logic [31:0] lookup_pc_i,
   input  logic        update_valid_i,
   input  logic        update_taken_i,
   input  logic [31:0] update_pc_i,
   input  logic [31:0] update_target_i,
   input  logic        mispredict_i,
   input  logic        pred_valid_i,
   input  logic        pred_taken_i,
   input  logic [31:0] pred_target_i,
   input  logic [15:0] stat_lookups_i,
   input  logic [15:0] stat_taken_i,
   input  logic [15:0] stat_updates_i,
   input  logic [15:0] stat_mispredicts_i,
   output int          checks_o,
   output int          pred_errors_o,
   output int          stat_errors_o
);

   localparam int IDX_W   = $clog2(NUM_BANKS) + $clog2(ROWS_PER_BANK);
   localparam int ENTRIES = NUM_BANKS * ROWS_PER_BANK;

   // Reference table, one entry per bank and row
   logic        row_valid [ENTRIES];
   logic [1:0]  row_state [ENTRIES]; // 0 strong not-taken up to 3 strong taken
   logic [31:0] row_tag [ENTRIES];
   logic [31:0] row_target [ENTRIES];

   // What the DUT shows after the next edge
   logic        exp_valid;
   logic        exp_taken;
   logic [31:0] exp_target;
   logic [15:0] exp_lookups;
   logic [15:0] exp_taken_cnt;
   logic [15:0] exp_updates;
   logic [15:0] exp_mispredicts;

   logic        armed = 1'b0;
   int          checks = 0;
   int          pred_errors = 0;
   int          stat_errors = 0;

   assign checks_o      = checks;
   assign pred_errors_o = pred_errors;
   assign stat_errors_o = stat_errors;

   // Bank bits sit below row bits, so both together give a unique entry
   function automatic int row_index(input logic [31:0] pc);
      return int'(pc[IDX_W:1]);
   endfunction

   function automatic logic [31:0] tag_of(input logic [31:0] pc);
      return pc >> (IDX_W + 1);
   endfunction

   task automatic compare(input string what, input logic [31:0] got,
                          input logic [31:0] exp, input bit is_stat);
      checks++;
      if (got !== exp) begin
         $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
         if (is_stat) begin
            stat_errors++;
         end else begin
            pred_errors++;
         end
      end
   endtask

   // Inputs and outputs are both settled at the falling edge
   always @(negedge clk_i) begin : model_step
      int         li;
      int         ui;
      logic       hit;
      logic [1:0] next_state;
      if (armed) begin
         compare("pred_valid_o", 32'(pred_valid_i), 32'(exp_valid), 1'b0);
         compare("pred_taken_o", 32'(pred_taken_i), 32'(exp_taken), 1'b0);
         compare("pred_target_o", pred_target_i, exp_target, 1'b0);
         compare("stat_lookups_o", 32'(stat_lookups_i), 32'(exp_lookups), 1'b1);
         compare("stat_taken_o", 32'(stat_taken_i), 32'(exp_taken_cnt), 1'b1);
         compare("stat_updates_o", 32'(stat_updates_i), 32'(exp_updates), 1'b1);
         compare("stat_mispredicts_o", 32'(stat_mispredicts_i), 32'(exp_mispredicts), 1'b1);
      end
      armed = 1'b1;
      if (rst_i) begin
         exp_valid       = 1'b0;
         exp_taken       = 1'b0;
         exp_target      = '0;
         exp_lookups     = '0;
         exp_taken_cnt   = '0;
         exp_updates     = '0;
         exp_mispredicts = '0;
         for (int i = 0; i < ENTRIES; i++) begin
            row_valid[i] = 1'b0;
            row_state[i] = 2'd0;
         end
      end else begin
         // Counters follow the prediction now on the outputs
         if (exp_valid) exp_lookups = exp_lookups + 16'd1;
         if (exp_taken) exp_taken_cnt = exp_taken_cnt + 16'd1;
         if (update_valid_i) exp_updates = exp_updates + 16'd1;
         if (mispredict_i) exp_mispredicts = exp_mispredicts + 16'd1;

         li = row_index(lookup_pc_i); // Reads the table before this cycle's update
         hit = lookup_valid_i && row_valid[li] && (row_tag[li] == tag_of(lookup_pc_i));
         exp_valid  = lookup_valid_i;
         exp_taken  = hit && row_state[li][1];
         exp_target = exp_taken ? row_target[li] : 32'd0;

         if (update_valid_i) begin
            ui = row_index(update_pc_i);
            if (row_valid[ui] && row_tag[ui] != tag_of(update_pc_i)) begin
               next_state = 2'd0; // Owner changes
            end else if (update_taken_i) begin
               next_state = (row_state[ui] == 2'd3) ? 2'd3 : row_state[ui] + 2'd1;
            end else begin
               next_state = (row_state[ui] == 2'd0) ? 2'd0 : row_state[ui] - 2'd1;
            end
            row_state[ui] = next_state;
            if (update_taken_i) begin
               row_valid[ui] = 1'b1;
               row_tag[ui]   = tag_of(update_pc_i);
               if (next_state[1]) row_target[ui] = update_target_i;
            end
         end
      end
   end

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock #(
   parameter int RESET_CYCLES = 16
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o; // Period of 10
   end

   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_o <= 1'b0; // Released on a rising edge
   end

endmodule

// ==== logic/branch_predictor_top.sv ====
module branch_predictor_top #(
   parameter int NUM_BANKS     = 4,
   parameter int ROWS_PER_BANK = 32
) (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        lookup_valid_i,
   input  logic [31:0] lookup_pc_i,
   input  logic        update_valid_i,
   input  logic        update_taken_i,
   input  logic [31:0] update_pc_i,
   input  logic [31:0] update_target_i,
   input  logic        mispredict_i,
   output logic        pred_valid_o,
   output logic        pred_taken_o,
   output logic [31:0] pred_target_o,
   output logic [15:0] stat_lookups_o,
   output logic [15:0] stat_taken_o,
   output logic [15:0] stat_updates_o,
   output logic [15:0] stat_mispredicts_o
);

   logic [$clog2(NUM_BANKS)-1:0] lookup_bank;
   logic                         pred_hit;

   bpu_bank_if #(.NUM_BANKS(NUM_BANKS), .ROWS_PER_BANK(ROWS_PER_BANK)) bank_if [NUM_BANKS] ();

   bank_router #(.NUM_BANKS(NUM_BANKS), .ROWS_PER_BANK(ROWS_PER_BANK)) u_router (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .lookup_valid_i  (lookup_valid_i),
      .lookup_pc_i     (lookup_pc_i),
      .update_valid_i  (update_valid_i),
      .update_taken_i  (update_taken_i),
      .update_pc_i     (update_pc_i),
      .update_target_i (update_target_i),
      .lookup_bank_o   (lookup_bank),
      .banks           (bank_if)
   );

   for (genvar g = 0; g < NUM_BANKS; g++) begin : g_banks
      pred_bank #(.NUM_BANKS(NUM_BANKS), .ROWS_PER_BANK(ROWS_PER_BANK)) u_bank (
         .clk_i (clk_i),
         .rst_i (rst_i),
         .bank  (bank_if[g])
      );
   end

   pred_merge #(.NUM_BANKS(NUM_BANKS)) u_merge (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .lookup_valid_i (lookup_valid_i),
      .lookup_bank_i  (lookup_bank),
      .banks          (bank_if),
      .pred_valid_o   (pred_valid_o),
      .pred_taken_o   (pred_taken_o),
      .pred_target_o  (pred_target_o),
      .pred_hit_o     (pred_hit)
   );

   pred_stats u_stats (
      .clk_i              (clk_i),
      .rst_i              (rst_i),
      .pred_valid_i       (pred_valid_o),
      .pred_taken_i       (pred_taken_o),
      .pred_hit_i         (pred_hit),
      .update_valid_i     (update_valid_i),
      .mispredict_i       (mispredict_i),
      .stat_lookups_o     (stat_lookups_o),
      .stat_taken_o       (stat_taken_o),
      .stat_updates_o     (stat_updates_o),
      .stat_mispredicts_o (stat_mispredicts_o)
   );

endmodule

// ==== logic/pred_stats.sv ====
module pred_stats (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     pred_valid_i,
   input  logic                     pred_taken_i,
   input  logic                     pred_hit_i,
   input  logic                     update_valid_i,
   input  logic                     mispredict_i,
   output bpu_stats_pkg::stat_cnt_t stat_lookups_o,
   output bpu_stats_pkg::stat_cnt_t stat_taken_o,
   output bpu_stats_pkg::stat_cnt_t stat_updates_o,
   output bpu_stats_pkg::stat_cnt_t stat_mispredicts_o
);

   logic count_taken;

   // A taken prediction always comes from a hit
   assign count_taken = pred_valid_i && pred_hit_i && pred_taken_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         stat_lookups_o     <= '0;
         stat_taken_o       <= '0;
         stat_updates_o     <= '0;
         stat_mispredicts_o <= '0;
      end else begin
         if (pred_valid_i) begin
            stat_lookups_o <= stat_lookups_o + 1'b1;
         end
         if (count_taken) begin
            stat_taken_o <= stat_taken_o + 1'b1;
         end
         if (update_valid_i) begin
            stat_updates_o <= stat_updates_o + 1'b1;
         end
         if (mispredict_i) begin
            stat_mispredicts_o <= stat_mispredicts_o + 1'b1; // Reported by the core
         end
      end
   end

endmodule

// ==== predictor/pred_merge.sv ====
module pred_merge #(
   parameter int NUM_BANKS = 4
) (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         lookup_valid_i,
   input  logic [$clog2(NUM_BANKS)-1:0] lookup_bank_i,
   bpu_bank_if.merge                    banks [NUM_BANKS],
   output logic                         pred_valid_o,
   output logic                         pred_taken_o,
   output bpu_pred_pkg::addr_t          pred_target_o,
   output logic                         pred_hit_o
);
   import bpu_pred_pkg::*;

   logic [NUM_BANKS-1:0] hit_vec;
   logic [NUM_BANKS-1:0] taken_vec;
   addr_t                target_vec [NUM_BANKS];

   logic                 sel_hit;
   logic                 sel_taken;

   for (genvar g = 0; g < NUM_BANKS; g++) begin : g_resp
      assign hit_vec[g]    = banks[g].resp_hit;
      assign taken_vec[g]  = banks[g].resp_taken;
      assign target_vec[g] = banks[g].resp_target;
   end

   assign sel_hit   = lookup_valid_i && hit_vec[lookup_bank_i];
   assign sel_taken = sel_hit && taken_vec[lookup_bank_i];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pred_valid_o  <= 1'b0;
         pred_hit_o    <= 1'b0;
         pred_taken_o  <= 1'b0;
         pred_target_o <= '0;
      end else begin
         pred_valid_o  <= lookup_valid_i;
         pred_hit_o    <= sel_hit;
         pred_taken_o  <= sel_taken;
         pred_target_o <= sel_taken ? target_vec[lookup_bank_i] : '0; // Zero on miss or not-taken
      end
   end

   a_taken_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
      pred_taken_o |-> pred_valid_o);

endmodule

// ==== predictor/pred_bank.sv ====
module pred_bank #(
   parameter int NUM_BANKS     = 4,
   parameter int ROWS_PER_BANK = 32
) (
   input logic      clk_i,
   input logic      rst_i,
   bpu_bank_if.bank bank
);
   import bpu_pred_pkg::*;

   localparam int BANK_W = $clog2(NUM_BANKS);
   localparam int ROW_W  = $clog2(ROWS_PER_BANK);
   localparam int TAG_W  = ADDR_W - 1 - BANK_W - ROW_W;

   // Control state, cleared on reset
   logic [ROWS_PER_BANK-1:0] valid_q;
   pred_state_t              state_q [ROWS_PER_BANK];

   // Payload
   logic [TAG_W-1:0]         tag_q [ROWS_PER_BANK];
   addr_t                    target_q [ROWS_PER_BANK];

   logic                     lookup_hit;
   pred_state_t              lookup_state;
   logic                     lookup_taken;

   pred_state_t              upd_state;
   logic                     upd_conflict;
   pred_state_t              upd_next;

   // Lookup path reads the table before any write of this cycle
   assign lookup_state = state_q[bank.lookup_row];
   assign lookup_hit   = bank.lookup_en && valid_q[bank.lookup_row] &&
                         (tag_q[bank.lookup_row] == bank.lookup_tag);
   assign lookup_taken = lookup_hit && lookup_state[1];

   assign bank.resp_hit    = lookup_hit;
   assign bank.resp_taken  = lookup_taken;
   assign bank.resp_target = lookup_taken ? target_q[bank.lookup_row] : '0;

   // Another branch owns this row
   assign upd_state    = state_q[bank.update_row];
   assign upd_conflict = valid_q[bank.update_row] &&
                         (tag_q[bank.update_row] != bank.update_tag);

   always_comb begin
      if (upd_conflict) begin
         upd_next = STRONG_NT; // Evict the old owner's history
      end else begin
         upd_next = sat_step(upd_state, bank.update_taken);
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q <= '0;
         for (int i = 0; i < ROWS_PER_BANK; i++) begin
            state_q[i] <= STRONG_NT;
         end
      end else if (bank.update_en) begin
         state_q[bank.update_row] <= upd_next;
         if (bank.update_taken) begin
            valid_q[bank.update_row] <= 1'b1; // Only taken branches allocate
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (bank.update_en && bank.update_taken) begin
         tag_q[bank.update_row] <= bank.update_tag;
         if (upd_next[1]) begin
            target_q[bank.update_row] <= bank.update_target; // Keep target of taken state
         end
      end
   end

   // Row comes from the router slice of the update address
   a_update_row_known: assert property (@(posedge clk_i) disable iff (rst_i)
      bank.update_en |-> !$isunknown(bank.update_row));

endmodule

// ==== predictor/bank_router.sv ====
module bank_router #(
   parameter int NUM_BANKS     = 4,
   parameter int ROWS_PER_BANK = 32
) (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         lookup_valid_i,
   input  bpu_pred_pkg::addr_t          lookup_pc_i,
   input  logic                         update_valid_i,
   input  logic                         update_taken_i,
   input  bpu_pred_pkg::addr_t          update_pc_i,
   input  bpu_pred_pkg::addr_t          update_target_i,
   output logic [$clog2(NUM_BANKS)-1:0] lookup_bank_o,
   bpu_bank_if.router                   banks [NUM_BANKS]
);
   import bpu_pred_pkg::*;

   localparam int BANK_W  = $clog2(NUM_BANKS);
   localparam int ROW_W   = $clog2(ROWS_PER_BANK);
   localparam int ROW_LSB = 1 + BANK_W;
   localparam int TAG_LSB = ROW_LSB + ROW_W;

   logic [BANK_W-1:0]    update_bank;
   logic [NUM_BANKS-1:0] lookup_en_vec;
   logic [NUM_BANKS-1:0] update_en_vec;

   assign lookup_bank_o = lookup_pc_i[1 +: BANK_W]; // Halfword aligned, skip bit 0
   assign update_bank   = update_pc_i[1 +: BANK_W];

   for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
      assign lookup_en_vec[g] = lookup_valid_i && (lookup_bank_o == BANK_W'(g));
      assign update_en_vec[g] = update_valid_i && (update_bank == BANK_W'(g));

      assign banks[g].lookup_en     = lookup_en_vec[g];
      assign banks[g].lookup_row    = lookup_pc_i[ROW_LSB +: ROW_W];
      assign banks[g].lookup_tag    = lookup_pc_i[ADDR_W-1:TAG_LSB];
      assign banks[g].update_en     = update_en_vec[g];
      assign banks[g].update_taken  = update_taken_i;
      assign banks[g].update_row    = update_pc_i[ROW_LSB +: ROW_W];
      assign banks[g].update_tag    = update_pc_i[ADDR_W-1:TAG_LSB];
      assign banks[g].update_target = update_target_i;
   end

   // Interleaving must never select two banks at once
   a_one_lookup_bank: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(lookup_en_vec));
   a_one_update_bank: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(update_en_vec));

endmodule

// ==== common/bpu_bank_if.sv ====
interface bpu_bank_if #(
   parameter int NUM_BANKS     = 4,
   parameter int ROWS_PER_BANK = 32
);
   import bpu_pred_pkg::*;

   localparam int BANK_W = $clog2(NUM_BANKS);
   localparam int ROW_W  = $clog2(ROWS_PER_BANK);
   localparam int TAG_W  = ADDR_W - 1 - BANK_W - ROW_W; // Bit 0 is never part of the tag

   logic             lookup_en;
   logic [ROW_W-1:0] lookup_row;
   logic [TAG_W-1:0] lookup_tag;

   logic             update_en;
   logic             update_taken;
   logic [ROW_W-1:0] update_row;
   logic [TAG_W-1:0] update_tag;
   addr_t            update_target;

   // Combinational answer of the bank
   logic             resp_hit;
   logic             resp_taken;
   addr_t            resp_target;

   modport router (output lookup_en, lookup_row, lookup_tag,
                   output update_en, update_taken, update_row, update_tag, update_target);

   modport bank (input  lookup_en, lookup_row, lookup_tag,
                 input  update_en, update_taken, update_row, update_tag, update_target,
                 output resp_hit, resp_taken, resp_target);

   modport merge (input resp_hit, resp_taken, resp_target);

endinterface

// ==== common/bpu_stats_pkg.sv ====
package bpu_stats_pkg;

   localparam int STAT_W = 16;

   // Wraps silently at 2^STAT_W
   typedef logic [STAT_W-1:0] stat_cnt_t;

endpackage

// ==== common/bpu_pred_pkg.sv ====
package bpu_pred_pkg;

   localparam int ADDR_W = 32;

   typedef logic [ADDR_W-1:0] addr_t;

   // Upper bit set means predict taken
   typedef enum logic [1:0] {
      STRONG_NT = 2'b00,
      WEAK_NT   = 2'b01,
      WEAK_T    = 2'b10,
      STRONG_T  = 2'b11
   } pred_state_t;

   // One saturating step toward the resolved outcome
   function automatic pred_state_t sat_step(input pred_state_t state, input logic taken);
      pred_state_t next;
      case (state)
         STRONG_NT: next = taken ? WEAK_NT  : STRONG_NT;
         WEAK_NT:   next = taken ? WEAK_T   : STRONG_NT;
         WEAK_T:    next = taken ? STRONG_T : WEAK_NT;
         STRONG_T:  next = taken ? STRONG_T : WEAK_T;
         default:   next = STRONG_NT;
      endcase
      return next;
   endfunction

endpackage
